// File: Makefile
# Verilator flow for the PC unit testbench.

TOP = pcUnitTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST OK" sim.log

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

// File: fetchSequencer.sv
// --------------------------------------
// Fetch sequencer: Wishbone reads of the
// opcode and operand, execute and halt.
// --------------------------------------

module fetchSequencer (
  input  logic         CP,
  input  logic         reset,
  output logic         wbCyc,
  output logic         wbStb,
  output pcPkg::addrT  wbAdr,
  input  logic         wbAck,
  output logic         captureOp,
  output logic         captureArg,
  output logic         execute,
  input  logic         isHalt,
  output logic         halted,
  pcCtrlIf.sequencer   ctrl
);

  pcPkg::fetchStateT state;
  pcPkg::fetchStateT nextState;
  logic request;
  logic nextRequest;
  logic byteDone;

  // Ack only counts while a request is out.
  assign byteDone = request && wbAck;

  assign wbCyc = request;
  assign wbStb = request;
  assign wbAdr = ctrl.pc;

  assign ctrl.advance = byteDone;
  assign captureOp    = byteDone && (state == pcPkg::FETCH_OP);
  assign captureArg   = byteDone && (state == pcPkg::FETCH_ARG);
  assign execute      = (state == pcPkg::EXECUTE);
  assign halted       = (state == pcPkg::HALTED);

  // ---------------------------------------
  // Next state
  // ---------------------------------------

  // Request drops on ack, giving one idle cycle before the operand read.
  always_comb begin
    nextState   = state;
    nextRequest = request;
    case (state)
      pcPkg::FETCH_OP: begin
        if (byteDone) begin
          nextRequest = 1'b0;
          nextState   = pcPkg::FETCH_ARG;
        end else begin
          nextRequest = 1'b1;
        end
      end
      pcPkg::FETCH_ARG: begin
        if (byteDone) begin
          nextRequest = 1'b0;
          nextState   = pcPkg::EXECUTE;
        end else begin
          nextRequest = 1'b1;
        end
      end
      pcPkg::EXECUTE: begin
        if (isHalt) begin
          nextState = pcPkg::HALTED;
        end else begin
          // Next opcode request goes out right after execute.
          nextRequest = 1'b1;
          nextState   = pcPkg::FETCH_OP;
        end
      end
      default: begin
        nextRequest = 1'b0;
      end
    endcase
  end

  always_ff @(posedge CP) begin
    if (reset) begin
      state   <= pcPkg::FETCH_OP;
      request <= 1'b0;
    end else begin
      state   <= nextState;
      request <= nextRequest;
    end
  end

endmodule

// File: flist.f
pcPkg.sv
pcCtrlIf.sv
programCounter.sv
instrRegister.sv
fetchSequencer.sv
pcUnit.sv
pcUnit_assertions.sv
pcUnitTb.sv

// File: instrRegister.sv
// --------------------------------------
// Instruction register and decoder that
// turns execute into PC load strobes.
// --------------------------------------

module instrRegister (
  input  logic         CP,
  input  logic         reset,
  input  logic         captureOp,
  input  logic         captureArg,
  input  logic         execute,
  input  pcPkg::byteT  wbDatIn,
  output logic         isHalt,
  pcCtrlIf.decoder     ctrl
);

  pcPkg::byteT opcode;
  pcPkg::byteT operand;
  logic isSetHi;
  logic isJmpFar;
  logic isJmpNear;

  // Opcode defaults to NOP so a stray execute does nothing.
  always_ff @(posedge CP) begin
    if (reset) begin
      opcode <= pcPkg::OP_NOP;
    end else if (captureOp) begin
      opcode <= wbDatIn;
    end
  end

  always_ff @(posedge CP) begin
    if (captureArg) begin
      operand <= wbDatIn;
    end
  end

  // ---------------------------------------
  // Decode
  // ---------------------------------------

  // Unknown opcodes fall through as NOP.
  assign isSetHi   = (opcode == pcPkg::OP_SETHI);
  assign isJmpFar  = (opcode == pcPkg::OP_JMPFAR);
  assign isJmpNear = (opcode == pcPkg::OP_JMPNEAR);
  assign isHalt    = (opcode == pcPkg::OP_HALT);

  // Strobes live only for the single execute cycle.
  assign ctrl.loadHiTmp = execute && isSetHi;
  assign ctrl.loadLo    = execute && (isJmpFar || isJmpNear);
  assign ctrl.loadHi    = execute && isJmpFar;

  assign ctrl.operand = operand;

endmodule

// File: pcCtrlIf.sv
// --------------------------------------
// Control link between fetch, decode
// and the program counter.
// --------------------------------------

interface pcCtrlIf;

  // Byte acknowledged, bump the PC.
  logic advance;

  // Execute strobes from the decoder.
  logic loadHiTmp;
  logic loadLo;
  logic loadHi;

  pcPkg::byteT operand;
  pcPkg::addrT pc;

  modport counter (
    input  advance,
    input  loadHiTmp,
    input  loadLo,
    input  loadHi,
    input  operand,
    output pc
  );

  modport sequencer (output advance, input pc);

  modport decoder (output loadHiTmp, loadLo, loadHi, operand);

endinterface

// File: pcPkg.sv
// --------------------------------------
// PC subsystem shared types and opcodes.
// --------------------------------------

package pcPkg;

  // ---------------------------------------
  // Widths
  // ---------------------------------------

  localparam int BYTE_W = 8;
  localparam int ADDR_W = 16;

  // One memory byte, opcode, operand or PC half.
  typedef logic [BYTE_W-1:0] byteT;

  // Full program address.
  typedef logic [ADDR_W-1:0] addrT;

  // ---------------------------------------
  // Opcodes
  // ---------------------------------------

  // Advance only.
  localparam byteT OP_NOP = 8'h00;

  // Operand into PCHITMP.
  localparam byteT OP_SETHI = 8'h01;

  // PCHI from PCHITMP, PCLO from operand.
  localparam byteT OP_JMPFAR = 8'h02;

  // PCLO from operand, PCHI kept.
  localparam byteT OP_JMPNEAR = 8'h03;

  // Stop fetching until reset.
  localparam byteT OP_HALT = 8'hFF;

  // ---------------------------------------
  // Sequencer
  // ---------------------------------------

  typedef enum logic [1:0] {
    FETCH_OP,
    FETCH_ARG,
    EXECUTE,
    HALTED
  } fetchStateT;

endpackage

// File: pcUnit.sv
// --------------------------------------
// PC unit top: counter, instruction
// register and Wishbone fetch sequencer.
// --------------------------------------

module pcUnit (
  input  logic         CP,
  input  logic         reset,
  output logic         wbCyc,
  output logic         wbStb,
  output pcPkg::addrT  wbAdr,
  input  pcPkg::byteT  wbDatIn,
  input  logic         wbAck,
  output pcPkg::byteT  pcHi,
  output pcPkg::byteT  pcLo,
  output logic         halted
);

  logic captureOp;
  logic captureArg;
  logic execute;
  logic isHalt;

  pcCtrlIf ctrl ();

  programCounter programCounter_i (
    .CP    (CP),
    .reset (reset),
    .ctrl  (ctrl.counter)
  );

  instrRegister instrRegister_i (
    .CP         (CP),
    .reset      (reset),
    .captureOp  (captureOp),
    .captureArg (captureArg),
    .execute    (execute),
    .wbDatIn    (wbDatIn),
    .isHalt     (isHalt),
    .ctrl       (ctrl.decoder)
  );

  fetchSequencer fetchSequencer_i (
    .CP         (CP),
    .reset      (reset),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbAdr      (wbAdr),
    .wbAck      (wbAck),
    .captureOp  (captureOp),
    .captureArg (captureArg),
    .execute    (execute),
    .isHalt     (isHalt),
    .halted     (halted),
    .ctrl       (ctrl.sequencer)
  );

  assign pcHi = ctrl.pc[15:8];
  assign pcLo = ctrl.pc[7:0];

endmodule

// File: pcUnitTb.sv
// --------------------------------------
// PC unit testbench with a Wishbone memory
// model and an instruction reference model.
// --------------------------------------

module pcUnitTb;

  localparam int HALF_PERIOD   = 20;
  localparam int DRIVE_DELAY   = 2;
  localparam int RAND_SEED     = 53416;
  localparam int FETCH_TIMEOUT = 20;
  localparam int HALT_TIMEOUT  = 20;
  localparam int HALT_WINDOW   = 30;
  localparam int MAX_INSTR     = 40;

  logic        CP;
  logic        reset;
  logic        wbCyc;
  logic        wbStb;
  pcPkg::addrT wbAdr;
  pcPkg::byteT wbDatIn;
  logic        wbAck;
  pcPkg::byteT pcHi;
  pcPkg::byteT pcLo;
  logic        halted;

  // Full 64K program space.
  pcPkg::byteT mem [0:65535];

  pcUnit pcUnit_i (
    .CP      (CP),
    .reset   (reset),
    .wbCyc   (wbCyc),
    .wbStb   (wbStb),
    .wbAdr   (wbAdr),
    .wbDatIn (wbDatIn),
    .wbAck   (wbAck),
    .pcHi    (pcHi),
    .pcLo    (pcLo),
    .halted  (halted)
  );

  initial begin
    CP = 1'b0;
    forever begin
      #HALF_PERIOD CP = ~CP;
    end
  end

  // --------------------------------------
  // Failure reporting
  // --------------------------------------

  task automatic abortRun();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic reportMismatch(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    abortRun();
  endtask

  task automatic reportTimeout(input string what);
    $display("Timed out at %0t because %s", $time, what);
    abortRun();
  endtask

  // --------------------------------------
  // Program image and reference model
  // --------------------------------------

  task automatic putInstr(input pcPkg::addrT adr, input pcPkg::byteT op, input pcPkg::byteT arg);
    pcPkg::addrT argAdr;
    argAdr      = adr + 16'd1;
    mem[adr]    = op;
    mem[argAdr] = arg;
  endtask

  task automatic loadProgram();
    for (int i = 0; i < 65536; i++) begin
      mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'hA5;
    end
    // Second pass through 0x0000 jumps high since PCHITMP is 0xFF by then.
    putInstr(16'h0000, pcPkg::OP_JMPFAR, 8'h10);
    for (int i = 0; i < 6; i++) begin
      mem[16'h0010 + 16'(2 * i)] = pcPkg::OP_NOP;
    end
    putInstr(16'h001C, pcPkg::OP_SETHI, 8'h12);
    putInstr(16'h001E, pcPkg::OP_JMPNEAR, 8'h40);
    putInstr(16'h0040, 8'h7E, 8'h33);
    putInstr(16'h0042, pcPkg::OP_JMPFAR, 8'h80);
    putInstr(16'h1280, pcPkg::OP_SETHI, 8'hFF);
    putInstr(16'h1282, pcPkg::OP_JMPNEAR, 8'h90);
    putInstr(16'h1290, pcPkg::OP_JMPFAR, 8'hFE);
    mem[16'hFFFE] = pcPkg::OP_NOP;
    mem[16'hFF10] = pcPkg::OP_NOP;
    putInstr(16'hFF12, pcPkg::OP_HALT, 8'h00);
  endtask

  // One instruction: both bytes advance the PC, then a jump overrides it.
  function automatic logic refStep(
    input  pcPkg::addrT pc,
    input  pcPkg::byteT hiTmp,
    output pcPkg::addrT nextPc,
    output pcPkg::byteT nextHiTmp
  );
    pcPkg::byteT op;
    pcPkg::byteT arg;
    pcPkg::addrT argAdr;
    argAdr    = pc + 16'd1;
    op        = mem[pc];
    arg       = mem[argAdr];
    nextPc    = pc + 16'd2;
    nextHiTmp = hiTmp;
    case (op)
      pcPkg::OP_SETHI:   nextHiTmp = arg;
      pcPkg::OP_JMPFAR:  nextPc = {hiTmp, arg};
      pcPkg::OP_JMPNEAR: nextPc = {nextPc[15:8], arg};
      default: begin
      end
    endcase
    return op == pcPkg::OP_HALT;
  endfunction

  // --------------------------------------
  // Wishbone memory model
  // --------------------------------------

  initial begin : memoryResponder
    int waitLeft;
    wbAck   = 1'b0;
    wbDatIn = '0;
    waitLeft = -1;
    void'($urandom(RAND_SEED));
    forever begin
      @(posedge CP);
      #DRIVE_DELAY;
      if (wbAck) begin
        wbAck    = 1'b0;
        waitLeft = -1;
      end else if (wbStb) begin
        if (waitLeft < 0) begin
          waitLeft = $urandom % 4;
        end
        if (waitLeft == 0) begin
          wbAck   = 1'b1;
          wbDatIn = mem[wbAdr];
        end else begin
          waitLeft--;
        end
      end
    end
  end

  // Handshake is seen at the falling edge before the ack edge.
  task automatic waitFetch(output pcPkg::addrT adr);
    int cycles;
    cycles = 0;
    @(negedge CP);
    while (!(wbStb === 1'b1 && wbAck === 1'b1)) begin
      cycles++;
      if (cycles > FETCH_TIMEOUT) begin
        reportTimeout("no acknowledged fetch arrived");
      end
      @(negedge CP);
    end
    assert (wbCyc === 1'b1)
      else reportMismatch($sformatf("fetch at %04h acknowledged without cyc", wbAdr));
    adr = wbAdr;
  endtask

  // --------------------------------------
  // Reset and comparison
  // --------------------------------------

  initial begin : checkRun
    pcPkg::addrT refPc;
    pcPkg::addrT nextPc;
    pcPkg::addrT argAdr;
    pcPkg::addrT adr;
    pcPkg::byteT refHiTmp;
    pcPkg::byteT nextHiTmp;
    logic refHalt;
    int instrCount;
    int cycles;
    reset = 1'b1;
    loadProgram();
    repeat (3) @(posedge CP);
    #DRIVE_DELAY;
    reset = 1'b0;
    assert (pcHi == 8'h00 && pcLo == 8'h00 && !halted && !wbCyc)
      else reportMismatch($sformatf("after reset pc=%02h%02h halted=%0b cyc=%0b",
                                    pcHi, pcLo, halted, wbCyc));
    @(posedge CP);
    #DRIVE_DELAY;
    assert (wbCyc && wbStb && wbAdr == 16'h0000)
      else reportMismatch($sformatf("first request cyc=%0b stb=%0b adr=%04h",
                                    wbCyc, wbStb, wbAdr));

    refPc      = '0;
    refHiTmp   = '0;
    refHalt    = 1'b0;
    instrCount = 0;
    while (!refHalt) begin
      instrCount++;
      if (instrCount > MAX_INSTR) begin
        reportTimeout("the program never reached HALT");
      end
      waitFetch(adr);
      assert (adr == refPc)
        else reportMismatch($sformatf("opcode fetch at %04h, expected %04h", adr, refPc));
      argAdr = refPc + 16'd1;
      waitFetch(adr);
      assert (adr == argAdr)
        else reportMismatch($sformatf("operand fetch at %04h, expected %04h", adr, argAdr));
      refHalt  = refStep(refPc, refHiTmp, nextPc, nextHiTmp);
      refPc    = nextPc;
      refHiTmp = nextHiTmp;
    end

    cycles = 0;
    @(negedge CP);
    while (!halted) begin
      cycles++;
      if (cycles > HALT_TIMEOUT) begin
        reportTimeout("halted did not rise after HALT");
      end
      @(negedge CP);
    end
    repeat (HALT_WINDOW) begin
      @(negedge CP);
      assert (!wbCyc)
        else reportMismatch($sformatf("request at %04h after halt", wbAdr));
    end
    assert ({pcHi, pcLo} == refPc)
      else reportMismatch($sformatf("final pc %02h%02h, expected %04h", pcHi, pcLo, refPc));
    assert (pcUnit_i.programCounter_i.pcHiTmp == refHiTmp)
      else reportMismatch($sformatf("final PCHITMP %02h, expected %02h",
                                    pcUnit_i.programCounter_i.pcHiTmp, refHiTmp));
    $display("TEST OK");
    $finish;
  end

endmodule

// File: pcUnit_assertions.sv
// --------------------------------------
// Wishbone and counter checks bound to
// the PC unit top level.
// --------------------------------------

module pcUnit_assertions (
  input logic        CP,
  input logic        reset,
  input logic        wbCyc,
  input logic        wbStb,
  input pcPkg::addrT wbAdr,
  input logic        wbAck,
  input logic        halted,
  input logic        execute,
  input pcPkg::byteT pcHi,
  input pcPkg::byteT pcLo
);

  pcPkg::addrT pc;

  assign pc = {pcHi, pcLo};

  // Request and address hold until ack.
  reqStable: assert property (
    @(posedge CP) disable iff (reset)
    (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr))
  ) else $error("Wishbone request or address changed before ack");

  haltIdle: assert property (
    @(posedge CP) disable iff (reset)
    halted |-> !wbCyc
  ) else $error("Wishbone cycle raised while halted");

  // Jumps land only on the edge that leaves execute.
  pcStep: assert property (
    @(posedge CP) disable iff (reset)
    (pc != $past(pc)) |-> ((pc == $past(pc) + 16'd1) || $past(execute))
  ) else $error("pc changed without an advance or an execute cycle");

endmodule

bind pcUnit pcUnit_assertions pcUnitAssertions_i (
  .CP      (CP),
  .reset   (reset),
  .wbCyc   (wbCyc),
  .wbStb   (wbStb),
  .wbAdr   (wbAdr),
  .wbAck   (wbAck),
  .halted  (halted),
  .execute (execute),
  .pcHi    (pcHi),
  .pcLo    (pcLo)
);

// File: programCounter.sv
// --------------------------------------
// Program counter: PCHI, PCLO, PCHITMP
// with increment, wrap and jump loads.
// --------------------------------------

module programCounter (
  input  logic      CP,
  input  logic      reset,
  pcCtrlIf.counter  ctrl
);

  pcPkg::byteT pcHi;
  pcPkg::byteT pcLo;
  pcPkg::byteT pcHiTmp;
  pcPkg::addrT pcNext;

  // Carry from PCLO ripples into PCHI, 0xFFFF wraps to 0x0000.
  assign pcNext = {pcHi, pcLo} + 16'd1;

  assign ctrl.pc = {pcHi, pcLo};

  // ---------------------------------------
  // Holding register for far jumps
  // ---------------------------------------

  always_ff @(posedge CP) begin
    if (reset) begin
      pcHiTmp <= '0;
    end else if (ctrl.loadHiTmp) begin
      pcHiTmp <= ctrl.operand;
    end
  end

  // ---------------------------------------
  // Counter halves
  // ---------------------------------------

  // A load wins over advance.
  always_ff @(posedge CP) begin
    if (reset) begin
      pcHi <= '0;
      pcLo <= '0;
    end else if (ctrl.loadLo || ctrl.loadHi) begin
      if (ctrl.loadLo) begin
        pcLo <= ctrl.operand;
      end
      if (ctrl.loadHi) begin
        pcHi <= pcHiTmp;
      end
    end else if (ctrl.advance) begin
      pcHi <= pcNext[15:8];
      pcLo <= pcNext[7:0];
    end
  end

endmodule
